// ==== verilog.f ====
+incdir+include
verilog/threadPkg.sv
verilog/threadCtrlIf.sv
verilog/threadCtrlRegs.sv
verilog/threadPcTable.sv
verilog/roundRobinSelect.sv
verilog/threadScheduler.sv
tests/tbClock.sv
tests/threadSchedulerTb.sv

// ==== Makefile ====
# Verilator build and run for the thread scheduler testbench

SOURCES := verilog.f $(wildcard include/*.svh verilog/*.sv tests/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
obj_dir/VthreadSchedulerTb: $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module threadSchedulerTb

# Fails unless the testbench reports a pass
run: obj_dir/VthreadSchedulerTb
	@out="$$(./obj_dir/VthreadSchedulerTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== tests/threadSchedulerTb.sv ====
// Thread scheduler testbench
// AXI4-Lite access tasks, round-robin reference model, issue monitor,
// protocol assertions, the test sequence and a cycle timeout

`timescale 1ns/1ps
`include "thread_macros.svh"

module threadSchedulerTb;
	import threadPkg::*;

	// The tests add up to roughly 700 cycles, most of them in the stalled
	// issues, and the limit leaves about four times that
	localparam int TIMEOUT_CYCLES = 3000;

	logic clk;
	logic rst;
	logic awvalid;
	logic awready;
	logic [`AXI_ADDR_WIDTH-1:0] awaddr;
	logic wvalid;
	logic wready;
	ThreadPc wdata;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	logic [`AXI_ADDR_WIDTH-1:0] araddr;
	logic rvalid;
	logic rready;
	ThreadPc rdata;
	logic [1:0] rresp;
	logic issueValid;
	logic issueReady;
	Tid issueTid;
	ThreadPc issuePc;
	logic issueFire;

	// Reference model state
	ThreadPc modelPc [`NTHREADS];
	ThreadMask modelMask;
	Tid modelLast;
	logic [31:0] fireCount;

	logic [31:0] lcgState = 32'h4226cf4d;
	logic readyRandom;
	int cycleCount;
	int errorCount;
	int testErrors;
	int testCount;
	string testName;

	tbClock #(.PERIOD(4.0), .RESET_CYCLES(2)) u_clock (.clk(clk), .rst(rst));

	threadScheduler u_threadScheduler (
		.clk(clk), .rst(rst),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.issueValid(issueValid), .issueReady(issueReady),
		.issueTid(issueTid), .issuePc(issuePc)
	);

	assign issueFire = issueValid && issueReady;

	// ======================================================================
	// Helpers and reference model
	// ======================================================================

	function automatic logic [31:0] rand32();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Predicts the next grant as the first enabled thread after the last one
	function automatic Tid nextTid(input Tid last, input ThreadMask mask);
		Tid t;
		t = last;
		for (int k = 0; k < `NTHREADS; k++) begin
			t = t + Tid'(1);
			if (mask[t])
				return t;
		end
		return last;
	endfunction

	function automatic logic [`AXI_ADDR_WIDTH-1:0] pcAddr(input int t);
		return `AXI_ADDR_WIDTH'(`REG_PC_BASE + 4 * t);
	endfunction

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual == expected) else begin
			$display("ERROR %s %s: expected %08h, actual %08h",
				testName, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErrors = errorCount;
	endtask

	task automatic endTest();
		testCount++;
		$display("test %s done, %0d failed checks", testName, errorCount - testErrors);
	endtask

	// ======================================================================
	// AXI4-Lite access
	// ======================================================================

	// Address and data go out together and the response is taken with bready high
	task automatic axiWrite(input logic [`AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		awvalid = 1'b1;
		wvalid = 1'b1;
		awaddr = addr;
		wdata = data;
		do @(posedge clk); while (!awready);
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		do @(posedge clk); while (!bvalid);
	endtask

	task automatic axiRead(input logic [`AXI_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
		@(negedge clk);
		arvalid = 1'b1;
		araddr = addr;
		do @(posedge clk); while (!arready);
		@(negedge clk);
		arvalid = 1'b0;
		do @(posedge clk); while (!rvalid);
		data = rdata;
	endtask

	// Disables every thread and waits until the issue slot has drained
	task automatic stopIssue();
		axiWrite(`REG_ENABLE, 32'h0);
		do @(posedge clk); while (issueValid);
	endtask

	// The model switches mask only once nothing from the old mask is in flight
	task automatic setMask(input ThreadMask mask);
		stopIssue();
		modelMask = mask;
		axiWrite(`REG_ENABLE, 32'(mask));
	endtask

	task automatic waitIssues(input int n);
		logic [31:0] target;
		target = fireCount + 32'(n);
		while (fireCount < target) @(posedge clk);
	endtask

	// ======================================================================
	// Issue monitor and assertions
	// ======================================================================

	// Every accepted issue is checked against the round-robin prediction
	always @(posedge clk) begin : issueMonitor
		Tid expTid;
		if (!rst && issueFire) begin
			expTid = nextTid(modelLast, modelMask);
			checkValue("issue tid", 32'(expTid), 32'(issueTid));
			checkValue("issue pc", modelPc[expTid], issuePc);
			modelPc[expTid] = modelPc[expTid] + 32'd4;
			modelLast = expTid;
			fireCount = fireCount + 32'd1;
		end
	end

	resetQuiet: assert property (@(posedge clk) rst |=> (!issueValid && !bvalid && !rvalid))
		else begin
			$display("%s: a valid output was high right after reset", testName);
			errorCount++;
		end

	issueHold: assert property (@(posedge clk) disable iff (rst)
			(issueValid && !issueReady) |=>
			(issueValid && $stable(issueTid) && $stable(issuePc)))
		else begin
			$display("%s: the issue port changed or dropped while stalled", testName);
			errorCount++;
		end

	enabledOnly: assert property (@(posedge clk) disable iff (rst)
			issueFire |-> modelMask[issueTid])
		else begin
			$display("%s: a disabled thread was issued", testName);
			errorCount++;
		end

	writeTogether: assert property (@(posedge clk) disable iff (rst)
			awready == wready)
		else begin
			$display("%s: write address and write data were not accepted together",
				testName);
			errorCount++;
		end

	respOkay: assert property (@(posedge clk) disable iff (rst)
			(bvalid || rvalid) |-> (bresp == 2'b00 && rresp == 2'b00))
		else begin
			$display("%s: an AXI response was not OKAY", testName);
			errorCount++;
		end

	// Random back-pressure on the issue port while enabled
	always @(negedge clk) begin : readyDriver
		logic [31:0] r;
		if (readyRandom) begin
			r = rand32();
			issueReady = r[16];
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles with tests still running", cycleCount);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		logic [31:0] data;
		ThreadMask mask;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b1;
		issueReady = 1'b1;
		readyRandom = 1'b0;
		for (int t = 0; t < `NTHREADS; t++)
			modelPc[t] = '0;
		modelMask = '0;
		modelLast = Tid'(`NTHREADS - 1);
		fireCount = '0;
		cycleCount = 0;
		errorCount = 0;
		testCount = 0;
		testName = "setup";
		@(negedge clk);
		while (rst) @(negedge clk);

		beginTest("resetState");
		axiRead(`REG_ENABLE, data);
		checkValue("enable mask", 32'h0, data);
		axiRead(`REG_ISSUE_COUNT, data);
		checkValue("issue count", 32'h0, data);
		endTest();

		// All threads stay disabled while the PCs are loaded
		beginTest("pcReadback");
		for (int t = 0; t < `NTHREADS; t++) begin
			modelPc[t] = rand32() & 32'hFFFF_FFFC;
			axiWrite(pcAddr(t), modelPc[t]);
		end
		for (int t = 0; t < `NTHREADS; t++) begin
			axiRead(pcAddr(t), data);
			checkValue("pc readback", modelPc[t], data);
		end
		endTest();

		beginTest("allEnabled");
		setMask(8'hFF);
		waitIssues(3 * `NTHREADS);
		endTest();

		beginTest("randomMask");
		repeat (8) begin
			mask = ThreadMask'(rand32() >> 8);
			if (mask == '0)
				mask = 8'h01;
			setMask(mask);
			waitIssues(12);
		end
		endTest();

		beginTest("randomStall");
		setMask(8'b1011_0110);
		readyRandom = 1'b1;
		waitIssues(150);
		@(negedge clk);
		readyRandom = 1'b0;
		issueReady = 1'b1;
		stopIssue();
		endTest();

		beginTest("issueCount");
		axiRead(`REG_ISSUE_COUNT, data);
		checkValue("issue count", fireCount, data);
		endTest();

		$display("%0d tests, %0d issues, %0d failed checks", testCount, fireCount, errorCount);
		if (errorCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== tests/tbClock.sv ====
// Testbench clock and reset source
// Free-running clock and a synchronous reset held for a fixed number of cycles

`timescale 1ns/1ps

module tbClock #(
	parameter real PERIOD = 4.0,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// Reset drops on a rising edge, so the DUT sees it high for exactly RESET_CYCLES edges
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== verilog/threadScheduler.sv ====
// Thread scheduler top level
// Register block, PC table and round-robin selector with AXI4-Lite
// and issue ports

`timescale 1ns/1ps
`include "thread_macros.svh"

module threadScheduler (
	input  logic                        clk,
	input  logic                        rst,
	// AXI4-Lite slave
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [`AXI_ADDR_WIDTH-1:0]  awaddr,
	input  logic                        wvalid,
	output logic                        wready,
	input  threadPkg::ThreadPc          wdata,
	output logic                        bvalid,
	input  logic                        bready,
	output logic [1:0]                  bresp,
	input  logic                        arvalid,
	output logic                        arready,
	input  logic [`AXI_ADDR_WIDTH-1:0]  araddr,
	output logic                        rvalid,
	input  logic                        rready,
	output threadPkg::ThreadPc          rdata,
	output logic [1:0]                  rresp,
	// Issue port
	output logic                        issueValid,
	input  logic                        issueReady,
	output threadPkg::Tid               issueTid,
	output threadPkg::ThreadPc          issuePc
);
	import threadPkg::*;

	threadCtrlIf ctrl ();

	logic issueFire;
	Tid pcReadTid;
	ThreadPc pcReadValue;

	// One pulse per accepted issue, feeds the PC advance and the counter
	assign issueFire = issueValid && issueReady;

	// ======================================================================
	// Blocks
	// ======================================================================

	threadCtrlRegs u_ctrlRegs (
		.clk         (clk),
		.rst         (rst),
		.awvalid     (awvalid),
		.awready     (awready),
		.awaddr      (awaddr),
		.wvalid      (wvalid),
		.wready      (wready),
		.wdata       (wdata),
		.bvalid      (bvalid),
		.bready      (bready),
		.bresp       (bresp),
		.arvalid     (arvalid),
		.arready     (arready),
		.araddr      (araddr),
		.rvalid      (rvalid),
		.rready      (rready),
		.rdata       (rdata),
		.rresp       (rresp),
		.ctrl        (ctrl.regs),
		.issueFire   (issueFire),
		.pcReadTid   (pcReadTid),
		.pcReadValue (pcReadValue)
	);

	threadPcTable u_pcTable (
		.clk         (clk),
		.rst         (rst),
		.ctrl        (ctrl.pcTable),
		.issueFire   (issueFire),
		.issueTid    (issueTid),
		.readPc      (issuePc),
		.pcReadTid   (pcReadTid),
		.pcReadValue (pcReadValue)
	);

	// The enable mask is the request vector of the selector
	roundRobinSelect u_select (
		.clk        (clk),
		.rst        (rst),
		.requests   (ctrl.enableMask),
		.issueReady (issueReady),
		.issueValid (issueValid),
		.issueTid   (issueTid)
	);

endmodule

// ==== verilog/roundRobinSelect.sv ====
// Round-robin thread selector
// Rotating-priority search over the request mask, plus the issue slot
// with its valid/ready handshake

`timescale 1ns/1ps
`include "thread_macros.svh"

module roundRobinSelect (
	input  logic                 clk,
	input  logic                 rst,
	input  threadPkg::ThreadMask requests,
	input  logic                 issueReady,
	output logic                 issueValid,
	output threadPkg::Tid        issueTid
);
	import threadPkg::*;

	Tid lastTid;
	Tid startTid;
	logic [2*`NTHREADS-1:0] shifted;
	ThreadMask rotated;
	Tid firstOne;
	Tid grantTid;
	logic anyRequest;
	logic slotLoad;

	// ======================================================================
	// Priority rotation
	// ======================================================================

	// Search begins one past the last grant and wraps naturally in Tid
	assign startTid = lastTid + Tid'(1);

	// Shift the mask down from the top half and fold the two halves,
	// which leaves bit k holding the request of thread startTid+k
	assign shifted = {requests, {`NTHREADS{1'b0}}} >> startTid;
	assign rotated = shifted[2*`NTHREADS-1:`NTHREADS] | shifted[`NTHREADS-1:0];

	// Lowest set bit of the rotated mask
	always_comb begin
		firstOne = '0;
		for (int k = `NTHREADS - 1; k >= 0; k--) begin
			if (rotated[k])
				firstOne = Tid'(k);
		end
	end

	// Undo the rotation to get the real thread number
	assign grantTid = firstOne + startTid;
	assign anyRequest = |requests;

	// ======================================================================
	// Issue slot
	// ======================================================================

	// Slot reloads when it is empty or being accepted this cycle
	assign slotLoad = !issueValid || issueReady;

	// After reset the last grant reads as the top thread, so thread 0
	// is the first one looked at
	always_ff @(posedge clk) begin
		if (rst) begin
			issueValid <= 1'b0;
			lastTid <= Tid'(`NTHREADS - 1);
		end else if (slotLoad) begin
			issueValid <= anyRequest;
			if (anyRequest)
				lastTid <= grantTid;
		end
	end

	// Thread id is only meaningful while issueValid is high
	// and is held still while the consumer stalls
	always_ff @(posedge clk) begin
		if (slotLoad && anyRequest)
			issueTid <= grantTid;
	end

endmodule

// ==== verilog/threadPcTable.sv ====
// Per-thread program counter table
// Software load, advance on issue and two combinational read ports

`timescale 1ns/1ps
`include "thread_macros.svh"

module threadPcTable (
	input  logic               clk,
	input  logic               rst,
	threadCtrlIf.pcTable       ctrl,
	input  logic               issueFire,
	input  threadPkg::Tid      issueTid,
	output threadPkg::ThreadPc readPc,
	input  threadPkg::Tid      pcReadTid,
	output threadPkg::ThreadPc pcReadValue
);
	import threadPkg::*;

	// Each instruction word is four bytes
	localparam ThreadPc INSN_BYTES = ThreadPc'(4);

	ThreadPc pcs [`NTHREADS];

	// ======================================================================
	// PC update
	// ======================================================================

	// The load is written last so it wins over an advance
	// of the same thread in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int t = 0; t < `NTHREADS; t++)
				pcs[t] <= '0;
		end else begin
			if (issueFire)
				pcs[issueTid] <= pcs[issueTid] + INSN_BYTES;
			if (ctrl.pcLoad)
				pcs[ctrl.pcLoadTid] <= ctrl.pcLoadValue;
		end
	end

	// ======================================================================
	// Read ports
	// ======================================================================

	// Issue side, follows the selector's current thread
	assign readPc = pcs[issueTid];

	// Software side, used by the register block
	assign pcReadValue = pcs[pcReadTid];

endmodule

// ==== verilog/threadCtrlRegs.sv ====
// AXI4-Lite register block for the thread scheduler
// Write and read channel control, register map decode, enable mask,
// PC load strobes and the completed-issue counter

`timescale 1ns/1ps
`include "thread_macros.svh"

module threadCtrlRegs (
	input  logic                        clk,
	input  logic                        rst,
	// Write address channel
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [`AXI_ADDR_WIDTH-1:0]  awaddr,
	// Write data channel
	input  logic                        wvalid,
	output logic                        wready,
	input  threadPkg::ThreadPc          wdata,
	// Write response channel
	output logic                        bvalid,
	input  logic                        bready,
	output logic [1:0]                  bresp,
	// Read address channel
	input  logic                        arvalid,
	output logic                        arready,
	input  logic [`AXI_ADDR_WIDTH-1:0]  araddr,
	// Read data channel
	output logic                        rvalid,
	input  logic                        rready,
	output threadPkg::ThreadPc          rdata,
	output logic [1:0]                  rresp,
	// Control toward the PC table and selector
	threadCtrlIf.regs                   ctrl,
	input  logic                        issueFire,
	// Second read port of the PC table
	output threadPkg::Tid               pcReadTid,
	input  threadPkg::ThreadPc          pcReadValue
);
	import threadPkg::*;

	// Every access completes with OKAY
	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic axiUp;
	logic wrFire;
	logic rdFire;
	ThreadMask enableMask;
	logic [31:0] issueCount;
	ThreadPc readData;

	// True when the address falls inside the per-thread PC window
	function automatic logic isPcAddr(input logic [`AXI_ADDR_WIDTH-1:0] addr);
		return (addr >= `REG_PC_BASE) && (addr < `REG_PC_BASE + 4 * `NTHREADS);
	endfunction

	// Thread number of a PC register, low two address bits are ignored
	function automatic Tid pcIndex(input logic [`AXI_ADDR_WIDTH-1:0] addr);
		logic [`AXI_ADDR_WIDTH-1:0] offset;
		offset = addr - `REG_PC_BASE;
		return offset[`TID_WIDTH+1:2];
	endfunction

	// ======================================================================
	// Channel handshakes
	// ======================================================================

	// Held low through reset and the cycle after, so no handshake can
	// land before the registers have settled
	always_ff @(posedge clk) begin
		if (rst)
			axiUp <= 1'b0;
		else
			axiUp <= 1'b1;
	end

	// AW and W are taken together, one outstanding response at a time
	assign wrFire = axiUp && awvalid && wvalid && !bvalid;
	assign awready = wrFire;
	assign wready = wrFire;

	// A read is taken only once the previous data has been consumed
	assign rdFire = axiUp && arvalid && !rvalid;
	assign arready = rdFire;

	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	// Write response rises the cycle after the handshake and waits for bready
	always_ff @(posedge clk) begin
		if (rst)
			bvalid <= 1'b0;
		else if (wrFire)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	// Read data follows the same pattern with rready
	always_ff @(posedge clk) begin
		if (rst)
			rvalid <= 1'b0;
		else if (rdFire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// ======================================================================
	// Register map
	// ======================================================================

	// Enable mask only takes the low bits of the data word
	always_ff @(posedge clk) begin
		if (rst)
			enableMask <= '0;
		else if (wrFire && awaddr == `REG_ENABLE)
			enableMask <= wdata[`NTHREADS-1:0];
	end

	assign ctrl.enableMask = enableMask;

	// PC writes go out as a strobe in the handshake cycle itself,
	// so the new value is in place by the time bvalid rises
	assign ctrl.pcLoad = wrFire && isPcAddr(awaddr);
	assign ctrl.pcLoadTid = pcIndex(awaddr);
	assign ctrl.pcLoadValue = wdata;

	// Counts completed issue handshakes, wraps silently
	// Software writes to this offset have no effect
	always_ff @(posedge clk) begin
		if (rst)
			issueCount <= '0;
		else if (issueFire)
			issueCount <= issueCount + 32'd1;
	end

	// The PC table read port follows the read address directly
	assign pcReadTid = pcIndex(araddr);

	// Read mux, anything unmapped reads as zero
	always_comb begin
		readData = '0;
		if (araddr == `REG_ENABLE)
			readData = ThreadPc'(enableMask);
		else if (araddr == `REG_ISSUE_COUNT)
			readData = issueCount;
		else if (isPcAddr(araddr))
			readData = pcReadValue;
	end

	// Data is captured at the address handshake and held with rvalid
	always_ff @(posedge clk) begin
		if (rdFire)
			rdata <= readData;
	end

endmodule

// ==== verilog/threadCtrlIf.sv ====
// Control interface from the register block to the PC table
// Carries the enable mask and the software PC load command

`timescale 1ns/1ps

interface threadCtrlIf;
	import threadPkg::*;

	// Threads allowed to issue, straight from the enable register
	ThreadMask enableMask;

	// Single-cycle strobe that overwrites one PC
	// There is no back-pressure, the table always takes it
	logic pcLoad;
	// Thread whose PC is overwritten
	Tid pcLoadTid;
	// New PC value for that thread
	ThreadPc pcLoadValue;

	// The register block owns every signal here
	modport regs (
		output enableMask,
		output pcLoad,
		output pcLoadTid,
		output pcLoadValue
	);

	// The PC table only consumes the load command
	modport pcTable (
		input pcLoad,
		input pcLoadTid,
		input pcLoadValue
	);

endinterface

// ==== verilog/threadPkg.sv ====
// Thread scheduler package
// Types for thread ids, program counters and per-thread masks

`include "thread_macros.svh"

package threadPkg;

	// ======================================================================
	// Thread identification
	// ======================================================================

	// Index of one hardware thread
	typedef logic [`TID_WIDTH-1:0] Tid;

	// One bit per thread, bit t belongs to thread t
	typedef logic [`NTHREADS-1:0] ThreadMask;

	// ======================================================================
	// Program state
	// ======================================================================

	// Byte address of the next instruction of a thread
	// Also the width of an AXI data word in this block
	typedef logic [`PC_WIDTH-1:0] ThreadPc;

endpackage

// ==== include/thread_macros.svh ====
// Shared sizing for the thread scheduler
// Thread count, id and PC widths, AXI address width and register offsets

`ifndef THREAD_MACROS_SVH
`define THREAD_MACROS_SVH

// Number of hardware threads in the barrel
`define NTHREADS 8
// Bits needed to name one thread
`define TID_WIDTH 3
// Program counter width in bits
`define PC_WIDTH 32

// The register window is 256 bytes wide
`define AXI_ADDR_WIDTH 8

// Byte offsets in the register map
`define REG_ENABLE      8'h00
`define REG_ISSUE_COUNT 8'h04
// The PC of thread t sits at REG_PC_BASE + 4*t
`define REG_PC_BASE     8'h40

`endif
